// File: list.f
src/vexe_pkg.sv
src/vexe_csr.sv
src/vexe_logic_alu.sv
src/vexe_arith_alu.sv
src/vexe_perm_alu.sv
src/vexe_alu.sv
src/vexe_top.sv
test/vexe_checker.sv
test/vexe_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the log for failure
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module vexe_tb \
    -o vexe_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/vexe_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0

// File: src/vexe_alu.sv
// Execute ALU with one register stage, accepts an op every cycle
// Sub-ALU results are OR-combined, each is zero outside its own opcodes
// Inactive lanes keep source A (tail undisturbed)
`timescale 1ns/1ps

module vexe_alu (
    input  logic                clk,
    input  logic                reset,
    input  vexe_pkg::vexe_op_t  op,
    input  vexe_pkg::vexe_cfg_t cfg,
    output vexe_pkg::vexe_res_t res
);

    vexe_pkg::vexe_vec_t            logic_res;
    vexe_pkg::vexe_vec_t            arith_res;
    vexe_pkg::vexe_vec_t            perm_res;
    logic [vexe_pkg::vexe_xlen-1:0] perm_int;
    vexe_pkg::vexe_vec_t            combined;
    vexe_pkg::vexe_vec_t            merged;

    vexe_logic_alu u_logic_alu (
        .opcode (op.opcode),
        .sew    (cfg.sew),
        .srca   (op.srca),
        .srcb   (op.srcb),
        .result (logic_res)
    );

    vexe_arith_alu u_arith_alu (
        .opcode (op.opcode),
        .sew    (cfg.sew),
        .srca   (op.srca),
        .srcb   (op.srcb),
        .result (arith_res)
    );

    vexe_perm_alu u_perm_alu (
        .opcode     (op.opcode),
        .sew        (cfg.sew),
        .srca       (op.srca),
        .scalar     (op.scalar),
        .result     (perm_res),
        .int_result (perm_int)
    );

    always_comb begin
        combined.raw = logic_res.raw | arith_res.raw | perm_res.raw;
        for (int i = 0; i < vexe_pkg::vexe_max_elems; i++)
            merged.b[i] = cfg.elem_active[i] ? combined.b[i] : op.srca.b[i];
    end

    always_ff @(posedge clk) begin
        res.vec        <= merged;
        res.int_result <= perm_int;
        if (reset)
            res.valid <= 1'b0;
        else
            res.valid <= op.valid;
    end

    // Opcode decode across the three sub-ALUs must not overlap
    a_one_source: assert property (@(posedge clk) disable iff (reset)
        op.valid |-> $onehot0({logic_res.raw != '0, arith_res.raw != '0, perm_res.raw != '0}));

endmodule

// File: src/vexe_arith_alu.sv
// Per-lane add, sub, signed min and max, and set-equal
// Add and sub wrap inside the lane, no carry crosses a lane boundary
// Output is zero for opcodes that belong to another ALU
`timescale 1ns/1ps

module vexe_arith_alu (
    input  vexe_pkg::vexe_opcode_e opcode,
    input  vexe_pkg::vexe_sew_e    sew,
    input  vexe_pkg::vexe_vec_t    srca,
    input  vexe_pkg::vexe_vec_t    srcb,
    output vexe_pkg::vexe_vec_t    result
);

    logic is_arith;

    // Operands arrive sign extended, so compares are signed at any width
    function automatic logic [31:0] arith_lane(
        vexe_pkg::vexe_opcode_e opc,
        logic signed [31:0]     a,
        logic signed [31:0]     b
    );
        case (opc)
            vexe_pkg::op_add: return a + b;
            vexe_pkg::op_sub: return a - b;
            vexe_pkg::op_min: return (a < b) ? a : b;
            vexe_pkg::op_max: return (a > b) ? a : b;
            default:          return (a == b) ? 32'hffff_ffff : 32'h0;
        endcase
    endfunction

    always_comb begin
        case (opcode)
            vexe_pkg::op_add,
            vexe_pkg::op_sub,
            vexe_pkg::op_min,
            vexe_pkg::op_max,
            vexe_pkg::op_seq: is_arith = 1'b1;
            default:          is_arith = 1'b0;
        endcase
    end

    always_comb begin
        logic [31:0] lane;

        result = '0;
        lane   = '0;
        if (is_arith) begin
            case (sew)
                vexe_pkg::sew8: begin
                    for (int i = 0; i < 8; i++) begin
                        lane = arith_lane(opcode, 32'($signed(srca.b[i])),
                                          32'($signed(srcb.b[i])));
                        result.b[i] = lane[7:0];
                    end
                end
                vexe_pkg::sew16: begin
                    for (int i = 0; i < 4; i++) begin
                        lane = arith_lane(opcode, 32'($signed(srca.h[i])),
                                          32'($signed(srcb.h[i])));
                        result.h[i] = lane[15:0];
                    end
                end
                vexe_pkg::sew32: begin
                    for (int i = 0; i < 2; i++) begin
                        lane = arith_lane(opcode, $signed(srca.w[i]), $signed(srcb.w[i]));
                        result.w[i] = lane;
                    end
                end
                default: result = '0;
            endcase
        end
    end

endmodule

// File: src/vexe_csr.sv
// APB register block for element width and vector length
// pready is tied high, so every transfer ends in its access cycle
// A sew write shrinks vl to the new lane count when vl would not fit
`timescale 1ns/1ps

module vexe_csr (
    input  logic                clk,
    input  logic                reset,
    input  logic [3:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output vexe_pkg::vexe_cfg_t cfg
);

    vexe_pkg::vexe_sew_e sew_q;
    logic [3:0]          vl_q;
    vexe_pkg::vexe_sew_e new_sew;
    logic                access;
    logic                hit_sew;
    logic                hit_vl;
    logic                sew_bad;
    logic                vl_bad;
    logic [1:0]          lane_shift;

    function automatic logic [3:0] lane_count(vexe_pkg::vexe_sew_e sew);
        case (sew)
            vexe_pkg::sew8:  return 4'd8;
            vexe_pkg::sew16: return 4'd4;
            vexe_pkg::sew32: return 4'd2;
            default:         return 4'd0;
        endcase
    endfunction

    assign access  = psel && penable;
    assign hit_sew = (paddr == vexe_pkg::vexe_addr_sew);
    assign hit_vl  = (paddr == vexe_pkg::vexe_addr_vl);
    assign new_sew = vexe_pkg::vexe_sew_e'(pwdata[1:0]);
    assign sew_bad = (pwdata > 32'd2);
    assign vl_bad  = (pwdata > {28'd0, lane_count(sew_q)});

    assign pready  = 1'b1;
    assign pslverr = access && (!(hit_sew || hit_vl) ||
                     (pwrite && ((hit_sew && sew_bad) || (hit_vl && vl_bad))));

    always_ff @(posedge clk) begin
        if (reset) begin
            sew_q <= vexe_pkg::sew8;
            vl_q  <= 4'd8;
        end else if (access && pwrite && !pslverr) begin
            if (hit_sew) begin
                sew_q <= new_sew;
                if (vl_q > lane_count(new_sew))
                    vl_q <= lane_count(new_sew);
            end else begin
                vl_q <= pwdata[3:0];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (hit_sew)
            prdata = {30'd0, sew_q};
        else if (hit_vl)
            prdata = {28'd0, vl_q};
    end

    // Byte lane i belongs to element i >> log2(bytes per element)
    always_comb begin
        case (sew_q)
            vexe_pkg::sew16: lane_shift = 2'd1;
            vexe_pkg::sew32: lane_shift = 2'd2;
            default:         lane_shift = 2'd0;
        endcase
        cfg.sew = sew_q;
        cfg.vl  = vl_q;
        for (int i = 0; i < vexe_pkg::vexe_max_elems; i++)
            cfg.elem_active[i] = (i >> lane_shift) < int'(vl_q);
    end

    a_vl_fits: assert property (@(posedge clk) disable iff (reset)
        vl_q <= lane_count(sew_q));

endmodule

// File: src/vexe_logic_alu.sv
// Bitwise and shift operations
// Shift amount is taken from source B's lane, modulo the lane width
// Output is zero for opcodes that belong to another ALU
`timescale 1ns/1ps

module vexe_logic_alu (
    input  vexe_pkg::vexe_opcode_e opcode,
    input  vexe_pkg::vexe_sew_e    sew,
    input  vexe_pkg::vexe_vec_t    srca,
    input  vexe_pkg::vexe_vec_t    srcb,
    output vexe_pkg::vexe_vec_t    result
);

    // Lane is passed both zero and sign extended, the caller truncates
    function automatic logic [31:0] shift_lane(
        vexe_pkg::vexe_opcode_e opc,
        logic [31:0]            a_zext,
        logic signed [31:0]     a_sext,
        logic [4:0]             amt
    );
        case (opc)
            vexe_pkg::op_sll: return a_zext << amt;
            vexe_pkg::op_srl: return a_zext >> amt;
            default:          return 32'(a_sext >>> amt);
        endcase
    endfunction

    always_comb begin
        logic [31:0] lane;

        result = '0;
        lane   = '0;
        case (opcode)
            vexe_pkg::op_and: result.raw = srca.raw & srcb.raw;
            vexe_pkg::op_or:  result.raw = srca.raw | srcb.raw;
            vexe_pkg::op_xor: result.raw = srca.raw ^ srcb.raw;
            vexe_pkg::op_sll, vexe_pkg::op_srl, vexe_pkg::op_sra: begin
                case (sew)
                    vexe_pkg::sew8: begin
                        for (int i = 0; i < 8; i++) begin
                            lane = shift_lane(opcode, 32'(srca.b[i]), 32'($signed(srca.b[i])),
                                              {2'b00, srcb.b[i][2:0]});
                            result.b[i] = lane[7:0];
                        end
                    end
                    vexe_pkg::sew16: begin
                        for (int i = 0; i < 4; i++) begin
                            lane = shift_lane(opcode, 32'(srca.h[i]), 32'($signed(srca.h[i])),
                                              {1'b0, srcb.h[i][3:0]});
                            result.h[i] = lane[15:0];
                        end
                    end
                    vexe_pkg::sew32: begin
                        for (int i = 0; i < 2; i++) begin
                            lane = shift_lane(opcode, srca.w[i], $signed(srca.w[i]),
                                              srcb.w[i][4:0]);
                            result.w[i] = lane;
                        end
                    end
                    default: result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule

// File: src/vexe_perm_alu.sv
// Scalar splat into every lane and lane-0 extract to the scalar result
// Both outputs are zero for opcodes that belong to another ALU
`timescale 1ns/1ps

module vexe_perm_alu (
    input  vexe_pkg::vexe_opcode_e               opcode,
    input  vexe_pkg::vexe_sew_e                  sew,
    input  vexe_pkg::vexe_vec_t                  srca,
    input  logic [vexe_pkg::vexe_xlen-1:0]       scalar,
    output vexe_pkg::vexe_vec_t                  result,
    output logic [vexe_pkg::vexe_xlen-1:0]       int_result
);

    always_comb begin
        result     = '0;
        int_result = '0;
        case (opcode)
            vexe_pkg::op_i2v: begin
                // Scalar truncated to the lane width
                case (sew)
                    vexe_pkg::sew8:  for (int i = 0; i < 8; i++) result.b[i] = scalar[7:0];
                    vexe_pkg::sew16: for (int i = 0; i < 4; i++) result.h[i] = scalar[15:0];
                    vexe_pkg::sew32: for (int i = 0; i < 2; i++) result.w[i] = scalar;
                    default:         result = '0;
                endcase
            end
            vexe_pkg::op_v2i: begin
                case (sew)
                    vexe_pkg::sew8:  int_result = 32'($signed(srca.b[0]));
                    vexe_pkg::sew16: int_result = 32'($signed(srca.h[0]));
                    vexe_pkg::sew32: int_result = srca.w[0];
                    default:         int_result = '0;
                endcase
            end
            default: begin
                result     = '0;
                int_result = '0;
            end
        endcase
    end

endmodule

// File: src/vexe_pkg.sv
// Shared types and constants for the vector execute stage
// One 64-bit vector word, split into 8, 16 or 32-bit lanes by the active sew
// Encoding 3 of the sew field is reserved and never reaches the ALUs

package vexe_pkg;

    localparam int vexe_xlen      = 32;
    localparam int vexe_vlen      = 64;
    localparam int vexe_max_elems = 8;

    // APB register map
    localparam logic [3:0] vexe_addr_sew = 4'h0;
    localparam logic [3:0] vexe_addr_vl  = 4'h4;

    typedef enum logic [3:0] {
        op_and = 4'd0,
        op_or  = 4'd1,
        op_xor = 4'd2,
        op_sll = 4'd3,
        op_srl = 4'd4,
        op_sra = 4'd5,
        op_add = 4'd6,
        op_sub = 4'd7,
        op_min = 4'd8,
        op_max = 4'd9,
        op_seq = 4'd10,
        op_i2v = 4'd11,
        op_v2i = 4'd12
    } vexe_opcode_e;

    typedef enum logic [1:0] {
        sew8  = 2'd0,
        sew16 = 2'd1,
        sew32 = 2'd2
    } vexe_sew_e;

    // Same word seen as bytes, halfwords, words or flat
    typedef union packed {
        logic [vexe_max_elems-1:0][7:0]    b;
        logic [vexe_max_elems/2-1:0][15:0] h;
        logic [vexe_max_elems/4-1:0][31:0] w;
        logic [vexe_vlen-1:0]              raw;
    } vexe_vec_t;

    typedef struct packed {
        vexe_sew_e                 sew;
        logic [3:0]                vl;
        // One bit per byte lane
        logic [vexe_max_elems-1:0] elem_active;
    } vexe_cfg_t;

    typedef struct packed {
        logic                 valid;
        vexe_opcode_e         opcode;
        vexe_vec_t            srca;
        vexe_vec_t            srcb;
        logic [vexe_xlen-1:0] scalar;
    } vexe_op_t;

    typedef struct packed {
        logic                 valid;
        vexe_vec_t            vec;
        logic [vexe_xlen-1:0] int_result;
    } vexe_res_t;

endpackage

// File: src/vexe_top.sv
// Vector execute stage top level
// Configuration arrives over APB, ops enter every cycle with no back-pressure
// Result appears one cycle after the op is sampled
`timescale 1ns/1ps

module vexe_top (
    input  logic                clk,
    input  logic                reset,
    // APB
    input  logic [3:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    // Execute
    input  vexe_pkg::vexe_op_t  op,
    output vexe_pkg::vexe_res_t res
);

    vexe_pkg::vexe_cfg_t cfg;

    vexe_csr u_csr (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg)
    );

    vexe_alu u_alu (
        .clk   (clk),
        .reset (reset),
        .op    (op),
        .cfg   (cfg),
        .res   (res)
    );

endmodule

// File: test/vexe_checker.sv
// Watches the vector execute stage and compares it with the expected values
// A result is due exactly one cycle after its op is sampled
// APB responses are checked only in access cycles flagged by the testbench
`timescale 1ns/1ps

module vexe_checker (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         prdata,
    input  logic                pready,
    input  logic                pslverr,
    input  vexe_pkg::vexe_op_t  op,
    input  vexe_pkg::vexe_res_t res,
    input  logic [127:0]        name,
    input  vexe_pkg::vexe_res_t expected,
    input  logic                apb_check,
    input  logic                exp_err,
    input  logic [31:0]         exp_rdata,
    output int                  errors
);

    vexe_pkg::vexe_res_t pend;
    logic [127:0]        pend_name;
    logic                pend_valid;
    int                  err_count = 0;

    assign errors = err_count;

    always @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else begin
            if (pend_valid) begin
                if (res.valid !== 1'b1) begin
                    $display("Result for %0s did not arrive one cycle after issue", pend_name);
                    err_count++;
                end else begin
                    if (res.vec.raw !== pend.vec.raw) begin
                        $display("** Error %0s: vec expected %h, actual %h",
                                 pend_name, pend.vec.raw, res.vec.raw);
                        err_count++;
                    end
                    if (res.int_result !== pend.int_result) begin
                        $display("** Error %0s: int_result expected %h, actual %h",
                                 pend_name, pend.int_result, res.int_result);
                        err_count++;
                    end
                end
            end else if (res.valid !== 1'b0) begin
                $display("Result valid at %0t although no op was issued", $time);
                err_count++;
            end
            pend_valid <= op.valid;
            pend       <= expected;
            pend_name  <= name;

            // APB access phase
            if (apb_check && psel && penable) begin
                if (pslverr !== exp_err || pready !== 1'b1) begin
                    $display("** Error %0s: pready/pslverr expected 1/%b, actual %b/%b",
                             name, exp_err, pready, pslverr);
                    err_count++;
                end
                if (!pwrite && prdata !== exp_rdata) begin
                    $display("** Error %0s: prdata expected %h, actual %h",
                             name, exp_rdata, prdata);
                    err_count++;
                end
            end else if (pslverr !== 1'b0) begin
                $display("pslverr is high outside an APB access phase at %0t", $time);
                err_count++;
            end
        end
    end

endmodule

// File: test/vexe_tb.sv
// Testbench for the vector execute stage, driven from a table of rows
// Expected values come from lane models of the op and register rules
// An APB row takes two cycles, its op is issued in the access cycle
`timescale 1ns/1ps

module vexe_tb;

    typedef enum int {no_apb, apb_write, apb_read} apb_kind_e;

    logic                clk;
    logic                reset;
    logic [3:0]          paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    vexe_pkg::vexe_op_t  op;
    vexe_pkg::vexe_res_t res;
    logic [127:0]        name;
    vexe_pkg::vexe_res_t expected;
    logic                apb_check;
    logic                exp_err;
    logic [31:0]         exp_rdata;
    int                  errors;

    logic [127:0]        t_name[$];
    vexe_pkg::vexe_op_t  t_op[$];
    vexe_pkg::vexe_res_t t_exp[$];
    apb_kind_e           t_kind[$];
    logic [3:0]          t_addr[$];
    logic [31:0]         t_data[$];
    logic                t_err[$];
    int                  seed;
    int                  m_sew;
    int                  m_vl;
    logic                rows_built = 1'b0;
    time                 limit;

    vexe_top UUT (
        .clk (clk), .reset (reset), .paddr (paddr), .psel (psel), .penable (penable),
        .pwrite (pwrite), .pwdata (pwdata), .prdata (prdata), .pready (pready),
        .pslverr (pslverr), .op (op), .res (res)
    );

    vexe_checker u_checker (
        .clk (clk), .reset (reset), .psel (psel), .penable (penable), .pwrite (pwrite),
        .prdata (prdata), .pready (pready), .pslverr (pslverr), .op (op), .res (res),
        .name (name), .expected (expected), .apb_check (apb_check), .exp_err (exp_err),
        .exp_rdata (exp_rdata), .errors (errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int lanes_for(int sew);
        return 8 >> sew;
    endfunction

    // Lane-wise model, lanes at or above vl keep source A
    function automatic logic [63:0] model_vec(vexe_pkg::vexe_opcode_e opc, int sew, int vl,
                                              logic [63:0] a, logic [63:0] b, logic [31:0] s);
        int          w;
        int          amt;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] r;
        logic [63:0] acc;
        longint      sa;
        longint      sb;

        w    = 8 << sew;
        mask = (64'd1 << w) - 64'd1;
        acc  = '0;
        for (int k = 0; k < 64 / w; k++) begin
            la  = (a >> (k * w)) & mask;
            lb  = (b >> (k * w)) & mask;
            sa  = $signed(la << (64 - w)) >>> (64 - w);
            sb  = $signed(lb << (64 - w)) >>> (64 - w);
            amt = int'(lb & 64'(w - 1));
            case (opc)
                vexe_pkg::op_and: r = la & lb;
                vexe_pkg::op_or:  r = la | lb;
                vexe_pkg::op_xor: r = la ^ lb;
                vexe_pkg::op_sll: r = la << amt;
                vexe_pkg::op_srl: r = la >> amt;
                vexe_pkg::op_sra: r = sa >>> amt;
                vexe_pkg::op_add: r = la + lb;
                vexe_pkg::op_sub: r = la - lb;
                vexe_pkg::op_min: r = (sa < sb) ? la : lb;
                vexe_pkg::op_max: r = (sa > sb) ? la : lb;
                vexe_pkg::op_seq: r = (la == lb) ? mask : 64'd0;
                vexe_pkg::op_i2v: r = 64'(s);
                default:          r = '0;
            endcase
            if (k >= vl)
                r = la;
            acc |= (r & mask) << (k * w);
        end
        return acc;
    endfunction

    function automatic logic [31:0] model_int(vexe_pkg::vexe_opcode_e opc, int sew,
                                              logic [63:0] a);
        int     w;
        longint sa;

        w  = 8 << sew;
        sa = $signed(a << (64 - w)) >>> (64 - w);
        return (opc == vexe_pkg::op_v2i) ? sa[31:0] : 32'd0;
    endfunction

    task automatic add_row(input string nm_s, input apb_kind_e kind, input logic [3:0] addr,
                           input logic [31:0] data, input logic valid,
                           input vexe_pkg::vexe_opcode_e opc, input logic [63:0] a,
                           input logic [63:0] b, input logic [31:0] s);
        vexe_pkg::vexe_op_t  o;
        vexe_pkg::vexe_res_t e;
        logic [127:0]        nm;
        logic                err;
        logic [31:0]         rd;

        $sformat(nm, "%s", nm_s);
        o.valid      = valid;
        o.opcode     = opc;
        o.srca.raw   = a;
        o.srcb.raw   = b;
        o.scalar     = s;
        // Op in the access cycle still sees the old configuration
        e.valid      = valid;
        e.vec.raw    = model_vec(opc, m_sew, m_vl, a, b, s);
        e.int_result = model_int(opc, m_sew, a);
        err = (kind != no_apb) && addr != vexe_pkg::vexe_addr_sew
              && addr != vexe_pkg::vexe_addr_vl;
        rd  = (addr == vexe_pkg::vexe_addr_sew) ? 32'(m_sew) : 32'(m_vl);
        if (err)
            rd = '0;
        if (kind == apb_write && !err) begin
            if (addr == vexe_pkg::vexe_addr_vl) begin
                err = data > 32'(lanes_for(m_sew));
                if (!err)
                    m_vl = int'(data);
            end else begin
                err = data > 32'd2;
                if (!err) begin
                    m_sew = int'(data);
                    // Narrower lane count trims vl
                    if (m_vl > lanes_for(m_sew))
                        m_vl = lanes_for(m_sew);
                end
            end
        end
        t_name.push_back(nm);
        t_op.push_back(o);
        t_exp.push_back(e);
        t_kind.push_back(kind);
        t_addr.push_back(addr);
        t_data.push_back(kind == apb_write ? data : rd);
        t_err.push_back(err);
    endtask

    task automatic add_apb(input string nm, input apb_kind_e kind, input logic [3:0] addr,
                           input logic [31:0] data);
        add_row(nm, kind, addr, data, 1'b0, vexe_pkg::op_and, '0, '0, '0);
    endtask

    task automatic add_random(input string nm, input vexe_pkg::vexe_opcode_e opc);
        add_row(nm, no_apb, 4'h0, 32'h0, 1'b1, opc, {$random(seed), $random(seed)},
                {$random(seed), $random(seed)}, $random(seed));
    endtask

    task automatic add_tail_set();
        vexe_pkg::vexe_opcode_e ops[6] = '{vexe_pkg::op_and, vexe_pkg::op_sll,
            vexe_pkg::op_add, vexe_pkg::op_min, vexe_pkg::op_i2v, vexe_pkg::op_v2i};

        for (int t = 0; t < 6; t++)
            add_random($sformatf("tail_%s_vl%0d", ops[t].name(), m_vl), ops[t]);
    endtask

    task automatic build_table();
        vexe_pkg::vexe_opcode_e opc;
        logic [63:0]            one;
        logic [63:0]            a;

        m_sew = 0;
        m_vl  = 8;
        add_apb("rd_sew_reset", apb_read, vexe_pkg::vexe_addr_sew, 32'd0);
        add_apb("rd_vl_reset", apb_read, vexe_pkg::vexe_addr_vl, 32'd0);
        for (int sw = 0; sw < 3; sw++) begin
            // Every byte carries out, so the sum shows the lane width in use
            a = {$random(seed), $random(seed)} | {8{8'h80}};
            add_row($sformatf("sew_write_op_%0d", sw), apb_write, vexe_pkg::vexe_addr_sew,
                    32'(sw), 1'b1, vexe_pkg::op_add, a, a, 32'h0);
            for (int o = 0; o < 13; o++) begin
                opc = vexe_pkg::vexe_opcode_e'(4'(o));
                add_random($sformatf("%s_%0d", opc.name(), 8 << sw), opc);
            end
            one = '0;
            for (int k = 0; k < lanes_for(sw); k++)
                one |= 64'd1 << (k * (8 << sw));
            add_row("add_wrap", no_apb, 4'h0, 32'h0, 1'b1, vexe_pkg::op_add, '1, one, '0);
            add_row("sub_wrap", no_apb, 4'h0, 32'h0, 1'b1, vexe_pkg::op_sub, '0, one, '0);
            add_row("seq_half", no_apb, 4'h0, 32'h0, 1'b1, vexe_pkg::op_seq, a,
                    a ^ 64'hffff_ffff_0000_0000, '0);
        end
        // vl stays 2 when going back to 16-bit lanes
        add_apb("wr_sew16", apb_write, vexe_pkg::vexe_addr_sew, 32'd1);
        add_tail_set();
        add_apb("wr_sew8", apb_write, vexe_pkg::vexe_addr_sew, 32'd0);
        add_apb("wr_vl3", apb_write, vexe_pkg::vexe_addr_vl, 32'd3);
        add_tail_set();
        add_apb("wr_vl_too_big", apb_write, vexe_pkg::vexe_addr_vl, 32'd9);
        add_apb("rd_vl_kept", apb_read, vexe_pkg::vexe_addr_vl, 32'd0);
        add_apb("wr_sew_reserved", apb_write, vexe_pkg::vexe_addr_sew, 32'd3);
        add_apb("rd_sew_kept", apb_read, vexe_pkg::vexe_addr_sew, 32'd0);
        add_apb("wr_bad_addr", apb_write, 4'h8, 32'h5);
        add_apb("rd_bad_addr", apb_read, 4'h8, 32'd0);
        add_apb("wr_sew32", apb_write, vexe_pkg::vexe_addr_sew, 32'd2);
        add_apb("rd_vl_trimmed", apb_read, vexe_pkg::vexe_addr_vl, 32'd0);
        add_apb("wr_vl1", apb_write, vexe_pkg::vexe_addr_vl, 32'd1);
        add_tail_set();
        add_apb("wr_vl0", apb_write, vexe_pkg::vexe_addr_vl, 32'd0);
        add_random("all_tail_xor", vexe_pkg::op_xor);
    endtask

    initial begin
        reset     = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        op        = '0;
        name      = '0;
        expected  = '0;
        apb_check = 1'b0;
        exp_err   = 1'b0;
        exp_rdata = '0;
        seed      = 45048;
        build_table();
        rows_built = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < t_op.size(); i++) begin
            if (t_kind[i] != no_apb) begin
                @(posedge clk);
                op        <= '0;
                apb_check <= 1'b0;
                psel      <= 1'b1;
                penable   <= 1'b0;
                pwrite    <= (t_kind[i] == apb_write);
                paddr     <= t_addr[i];
                pwdata    <= t_data[i];
            end
            @(posedge clk);
            psel      <= (t_kind[i] != no_apb);
            penable   <= (t_kind[i] != no_apb);
            apb_check <= (t_kind[i] != no_apb);
            exp_err   <= t_err[i];
            exp_rdata <= t_data[i];
            op        <= t_op[i];
            expected  <= t_exp[i];
            name      <= t_name[i];
        end
        @(posedge clk);
        psel      <= 1'b0;
        penable   <= 1'b0;
        apb_check <= 1'b0;
        op        <= '0;
        repeat (3) @(posedge clk);
        $display("Rows applied: %0d, errors: %0d", t_op.size(), errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // Each row needs at most two cycles, plus reset and drain
    initial begin
        wait (rows_built);
        limit = (2 * t_op.size() + 20) * 40;
        #(limit);
        $display("Simulation timed out before all rows were applied");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
